/* mips_params.svh */
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// instruction and datapath width
`define NB_DATA     32

// register file geometry
`define NB_REG_ADDR 5
`define REG_COUNT   32

// first fetch address out of reset
`define PC_RESET    32'h0000_0000

`endif

/* mips_isa_pkg.sv */
`default_nettype none
`include "mips_params.svh"

package mips_isa_pkg;

    // instruction field types
    typedef logic [`NB_REG_ADDR-1:0] reg_addr_t;
    typedef logic [4:0]              shamt_t;
    typedef logic [15:0]             imm16_t;

    // primary opcode, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LB    = 6'h20,
        OP_LH    = 6'h21,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // r-type funct, instr[5:0]
    typedef enum logic [5:0] {
        F_SLL = 6'h00,  // also the nop encoding
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_SLT = 6'h2a
    } funct_e;

endpackage

`default_nettype wire

/* mips_ctrl_pkg.sv */
`default_nettype none

package mips_ctrl_pkg;

    // alu operation class, resolved further in ex
    typedef enum logic [1:0] {
        ALUOP_ADD   = 2'd0,
        ALUOP_SUB   = 2'd1,
        ALUOP_FUNCT = 2'd2,  // look at funct
        ALUOP_LOGIC = 2'd3   // andi / ori
    } alu_op_e;

    // second alu operand select
    typedef enum logic [1:0] {
        SRC_REG   = 2'd0,
        SRC_IMM   = 2'd1,
        SRC_SHAMT = 2'd2
    } alu_src_e;

    // load/store access size
    typedef enum logic [1:0] {
        W_WORD = 2'd0,
        W_HALF = 2'd1,
        W_BYTE = 2'd2
    } mem_width_e;

    typedef enum logic {
        HZ_RUN    = 1'b0,
        HZ_BUBBLE = 1'b1  // bubble just went into id/ex
    } hazard_state_e;

endpackage

`default_nettype wire

/* ctrl_if.sv */
`default_nettype none

// decoded control bundle, combinational and valid every cycle
interface ctrl_if import mips_ctrl_pkg::*; ();

    logic       jump;
    logic       branch;
    logic       reg_dst;     // write rd instead of rt
    logic       mem_to_reg;
    logic       mem_read;
    logic       mem_write;
    logic       imm_flag;    // instruction carries an immediate
    logic       sign_flag;   // sign-extend the immediate
    logic       reg_write;
    alu_src_e   alu_src;
    alu_op_e    alu_op;
    mem_width_e width;

    modport drive (
        output jump, branch, reg_dst, mem_to_reg, mem_read, mem_write,
        output imm_flag, sign_flag, reg_write, alu_src, alu_op, width
    );

    modport take (
        input  jump, branch, reg_dst, mem_to_reg, mem_read, mem_write,
        input  imm_flag, sign_flag, reg_write, alu_src, alu_op, width
    );

endinterface

`default_nettype wire

/* pc_counter.sv */
`default_nettype none
`include "mips_params.svh"

module pc_counter (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_hold,   // external or load-use stall
    output logic [`NB_DATA-1:0] o_pc,
    output logic [`NB_DATA-1:0] o_pc4
);

    logic [`NB_DATA-1:0] pc_q;

    // sequential successor, also the link value
    assign o_pc4 = pc_q + (`NB_DATA)'(4);
    assign o_pc  = pc_q;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q <= `PC_RESET;
        end else if (!i_hold) begin
            pc_q <= o_pc4;
        end
    end

endmodule

`default_nettype wire

/* hazard_fsm.sv */
`default_nettype none
`include "mips_params.svh"

module hazard_fsm
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_freeze,       // downstream stall
    input  logic                i_ex_mem_read,  // load sitting in id/ex
    input  reg_addr_t           i_ex_rt,
    input  logic [`NB_DATA-1:0] i_if_instr,
    output logic                o_stall
);

    hazard_state_e state;
    hazard_state_e state_nxt;
    reg_addr_t     if_rs;
    reg_addr_t     if_rt;
    logic          load_use;

    assign if_rs = i_if_instr[25:21];
    assign if_rt = i_if_instr[20:16];

    // load target feeds the word being fetched
    assign load_use = i_ex_mem_read && (i_ex_rt != '0) &&
                      ((i_ex_rt == if_rs) || (i_ex_rt == if_rt));

    // held off while frozen so the stall is a single cycle
    assign o_stall = (state == HZ_RUN) && load_use && !i_freeze;

    always_comb begin
        state_nxt = state;
        case (state)
            HZ_RUN: begin
                if (o_stall) begin
                    state_nxt = HZ_BUBBLE;
                end
            end
            HZ_BUBBLE: begin
                if (!i_freeze) begin
                    state_nxt = HZ_RUN;  // never two bubbles back to back
                end
            end
            default: state_nxt = HZ_RUN;
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= HZ_RUN;
        end else begin
            state <= state_nxt;
        end
    end

endmodule

`default_nettype wire

/* register_file.sv */
`default_nettype none
`include "mips_params.svh"

module register_file
    import mips_isa_pkg::*;
(
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_we,
    input  reg_addr_t           i_wr_addr,
    input  logic [`NB_DATA-1:0] i_wr_data,
    input  reg_addr_t           i_rd_addr1,
    input  reg_addr_t           i_rd_addr2,
    output logic [`NB_DATA-1:0] o_rd_data1,
    output logic [`NB_DATA-1:0] o_rd_data2
);

    logic [`NB_DATA-1:0] regs [`REG_COUNT];
    logic                wr_live;

    assign wr_live = i_we && (i_wr_addr != '0);  // r0 writes dropped

    // r0 reads zero, same-cycle write is forwarded
    function automatic logic [`NB_DATA-1:0] read_port(input reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_live && (addr == i_wr_addr)) begin
            return i_wr_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        o_rd_data1 = read_port(i_rd_addr1);
        o_rd_data2 = read_port(i_rd_addr2);
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

endmodule

`default_nettype wire

/* control_unit.sv */
`default_nettype none

module control_unit
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  opcode_e      i_opcode,
    input  funct_e       i_funct,
    ctrl_if.drive        ctrl
);

    always_comb begin
        // all-zero bundle unless a row below matches
        ctrl.jump       = 1'b0;
        ctrl.branch     = 1'b0;
        ctrl.reg_dst    = 1'b0;
        ctrl.mem_to_reg = 1'b0;
        ctrl.mem_read   = 1'b0;
        ctrl.mem_write  = 1'b0;
        ctrl.imm_flag   = 1'b0;
        ctrl.sign_flag  = 1'b0;
        ctrl.reg_write  = 1'b0;
        ctrl.alu_src    = SRC_REG;
        ctrl.alu_op     = ALUOP_ADD;
        ctrl.width      = W_WORD;

        case (i_opcode)
            OP_RTYPE: begin
                case (i_funct)
                    F_ADD, F_SUB, F_AND, F_OR, F_SLT, F_SLL: begin
                        ctrl.reg_dst   = 1'b1;
                        ctrl.reg_write = 1'b1;
                        ctrl.alu_op    = ALUOP_FUNCT;
                        if (i_funct == F_SLL) begin
                            ctrl.alu_src = SRC_SHAMT;  // shift amount from instr
                        end
                    end
                    default: ;
                endcase
            end
            OP_ADDI: begin
                ctrl.imm_flag  = 1'b1;
                ctrl.sign_flag = 1'b1;
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = SRC_IMM;
            end
            OP_ANDI, OP_ORI: begin
                ctrl.imm_flag  = 1'b1;  // zero-extended
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = SRC_IMM;
                ctrl.alu_op    = ALUOP_LOGIC;
            end
            OP_LB, OP_LH, OP_LW: begin
                ctrl.imm_flag   = 1'b1;
                ctrl.sign_flag  = 1'b1;
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.alu_src    = SRC_IMM;
                ctrl.width      = (i_opcode == OP_LH) ? W_HALF :
                                  (i_opcode == OP_LB) ? W_BYTE : W_WORD;
            end
            OP_SW: begin
                ctrl.imm_flag  = 1'b1;
                ctrl.sign_flag = 1'b1;
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = SRC_IMM;
            end
            OP_BEQ: begin
                ctrl.branch    = 1'b1;
                ctrl.sign_flag = 1'b1;  // word offset
                ctrl.alu_op    = ALUOP_SUB;
            end
            OP_J: ctrl.jump = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* instruction_decode.sv */
`default_nettype none
`include "mips_params.svh"

module instruction_decode
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic [`NB_DATA-1:0] i_instruction,
    input  logic [`NB_DATA-1:0] i_pcounter4,
    input  logic                i_wb_we,
    input  reg_addr_t           i_wb_addr,
    input  logic [`NB_DATA-1:0] i_wb_data,
    input  logic                i_stall,   // freeze everything
    input  logic                i_bubble,  // load-use, insert nop
    output reg_addr_t           o_rs,
    output reg_addr_t           o_rt,
    output reg_addr_t           o_rd,
    output logic [`NB_DATA-1:0] o_reg_da,
    output logic [`NB_DATA-1:0] o_reg_db,
    output logic [`NB_DATA-1:0] o_immediate,
    output opcode_e             o_opcode,
    output shamt_t              o_shamt,
    output funct_e              o_func,
    output logic [25:0]         o_addr,    // jump target field
    output logic [`NB_DATA-1:0] o_pc4,
    output logic                o_jump,
    output logic                o_branch,
    output logic                o_reg_dst,
    output logic                o_mem_to_reg,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output logic                o_imm_flag,
    output logic                o_sign_flag,
    output logic                o_reg_write,
    output alu_src_e            o_alu_src,
    output alu_op_e             o_alu_op,
    output mem_width_e          o_width
);

    reg_addr_t           rs;
    reg_addr_t           rt;
    imm16_t              imm;
    opcode_e             opcode;
    funct_e              funct;
    logic [`NB_DATA-1:0] rd_data1;
    logic [`NB_DATA-1:0] rd_data2;
    logic [`NB_DATA-1:0] imm_ext;

    ctrl_if ctrl ();

    assign rs     = i_instruction[25:21];
    assign rt     = i_instruction[20:16];
    assign imm    = i_instruction[15:0];
    assign opcode = opcode_e'(i_instruction[31:26]);
    assign funct  = funct_e'(i_instruction[5:0]);

    // andi/ori zero-extend
    assign imm_ext = ctrl.sign_flag ? {{(`NB_DATA-16){imm[15]}}, imm}
                                    : {{(`NB_DATA-16){1'b0}}, imm};

    register_file u_regs (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_we       (i_wb_we),
        .i_wr_addr  (i_wb_addr),
        .i_wr_data  (i_wb_data),
        .i_rd_addr1 (rs),
        .i_rd_addr2 (rt),
        .o_rd_data1 (rd_data1),
        .o_rd_data2 (rd_data2)
    );

    control_unit u_ctrl (
        .i_opcode (opcode),
        .i_funct  (funct),
        .ctrl     (ctrl)
    );

    // control half of id/ex
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_jump       <= 1'b0;
            o_branch     <= 1'b0;
            o_reg_dst    <= 1'b0;
            o_mem_to_reg <= 1'b0;
            o_mem_read   <= 1'b0;
            o_mem_write  <= 1'b0;
            o_imm_flag   <= 1'b0;
            o_sign_flag  <= 1'b0;
            o_reg_write  <= 1'b0;
            o_alu_src    <= SRC_REG;
            o_alu_op     <= ALUOP_ADD;
            o_width      <= W_WORD;
        end else if (!i_stall) begin
            o_jump       <= ctrl.jump & ~i_bubble;
            o_branch     <= ctrl.branch & ~i_bubble;
            o_reg_dst    <= ctrl.reg_dst & ~i_bubble;
            o_mem_to_reg <= ctrl.mem_to_reg & ~i_bubble;
            o_mem_read   <= ctrl.mem_read & ~i_bubble;
            o_mem_write  <= ctrl.mem_write & ~i_bubble;
            o_imm_flag   <= ctrl.imm_flag & ~i_bubble;
            o_sign_flag  <= ctrl.sign_flag & ~i_bubble;
            o_reg_write  <= ctrl.reg_write & ~i_bubble;
            o_alu_src    <= i_bubble ? SRC_REG : ctrl.alu_src;
            o_alu_op     <= i_bubble ? ALUOP_ADD : ctrl.alu_op;
            o_width      <= i_bubble ? W_WORD : ctrl.width;
        end
    end

    // payload half, a bubble becomes sll r0,r0,0
    always_ff @(posedge clk) begin
        if (!i_stall) begin
            o_rs        <= i_bubble ? '0 : rs;
            o_rt        <= i_bubble ? '0 : rt;
            o_rd        <= i_bubble ? '0 : i_instruction[15:11];
            o_reg_da    <= i_bubble ? '0 : rd_data1;
            o_reg_db    <= i_bubble ? '0 : rd_data2;
            o_immediate <= i_bubble ? '0 : imm_ext;
            o_opcode    <= i_bubble ? OP_RTYPE : opcode;
            o_shamt     <= i_bubble ? '0 : i_instruction[10:6];
            o_func      <= i_bubble ? F_SLL : funct;
            o_addr      <= i_bubble ? '0 : i_instruction[25:0];
            o_pc4       <= i_bubble ? '0 : i_pcounter4;
        end
    end

endmodule

`default_nettype wire

/* mips_decode_top.sv */
`default_nettype none
`include "mips_params.svh"

module mips_decode_top
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
(
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic [`NB_DATA-1:0] i_instr,         // word at o_pc, same cycle
    input  logic                i_stall,
    input  logic                i_wb_we,
    input  reg_addr_t           i_wb_addr,
    input  logic [`NB_DATA-1:0] i_wb_data,
    output logic [`NB_DATA-1:0] o_pc,
    output logic                o_hazard_stall,
    output reg_addr_t           o_rs,
    output reg_addr_t           o_rt,
    output reg_addr_t           o_rd,
    output logic [`NB_DATA-1:0] o_reg_da,
    output logic [`NB_DATA-1:0] o_reg_db,
    output logic [`NB_DATA-1:0] o_immediate,
    output opcode_e             o_opcode,
    output shamt_t              o_shamt,
    output funct_e              o_func,
    output logic [25:0]         o_addr,
    output logic [`NB_DATA-1:0] o_pc4,
    output logic                o_jump,
    output logic                o_branch,
    output logic                o_reg_dst,
    output logic                o_mem_to_reg,
    output logic                o_mem_read,
    output logic                o_mem_write,
    output logic                o_imm_flag,
    output logic                o_sign_flag,
    output logic                o_reg_write,
    output alu_src_e            o_alu_src,
    output alu_op_e             o_alu_op,
    output mem_width_e          o_width
);

    logic                pc_hold;
    logic [`NB_DATA-1:0] pc4;

    assign pc_hold = i_stall | o_hazard_stall;  // refetch same pc

    pc_counter u_pc (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_hold  (pc_hold),
        .o_pc    (o_pc),
        .o_pc4   (pc4)
    );

    // watches the load currently in id/ex
    hazard_fsm u_hazard (
        .clk           (clk),
        .i_rst_n       (i_rst_n),
        .i_freeze      (i_stall),
        .i_ex_mem_read (o_mem_read),
        .i_ex_rt       (o_rt),
        .i_if_instr    (i_instr),
        .o_stall       (o_hazard_stall)
    );

    instruction_decode u_decode (
        .*,
        .i_instruction (i_instr),
        .i_pcounter4   (pc4),
        .i_bubble      (o_hazard_stall)
    );

endmodule

`default_nettype wire

/* mips_decode_properties.sv */
`default_nettype none
`include "mips_params.svh"

module mips_decode_properties (
    input  logic                clk,
    input  logic                i_rst_n,
    input  logic                i_stall,
    input  logic                o_hazard_stall,
    input  logic [`NB_DATA-1:0] o_pc,
    input  logic                o_jump,
    input  logic                o_branch,
    input  logic                o_reg_dst,
    input  logic                o_mem_to_reg,
    input  logic                o_mem_read,
    input  logic                o_mem_write,
    input  logic                o_imm_flag,
    input  logic                o_sign_flag,
    input  logic                o_reg_write
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [8:0] ctrl_bits;
    logic       any_ctrl;

    assign ctrl_bits = {o_jump, o_branch, o_reg_dst, o_mem_to_reg, o_mem_read,
                        o_mem_write, o_imm_flag, o_sign_flag, o_reg_write};
    assign any_ctrl  = |ctrl_bits;

    // first edge after release still shows the reset state
    a_reset_state: assert property (@(posedge clk)
        $rose(i_rst_n) |-> (o_pc == `PC_RESET) && !any_ctrl && !o_hazard_stall)
        else $error("ID/EX or pc not in reset state after reset release");

    a_single_stall: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_hazard_stall |=> !o_hazard_stall)
        else $error("load-use stall lasted more than one cycle");

    a_clean_bubble: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_hazard_stall |=> !any_ctrl)
        else $error("bubble in ID/EX carries control bits");

    a_freeze_pc: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_stall |=> $stable(o_pc) && $stable(ctrl_bits))
        else $error("pc or ID/EX controls moved under external stall");

endmodule

bind mips_decode_top mips_decode_properties u_props (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_stall        (i_stall),
    .o_hazard_stall (o_hazard_stall),
    .o_pc           (o_pc),
    .o_jump         (o_jump),
    .o_branch       (o_branch),
    .o_reg_dst      (o_reg_dst),
    .o_mem_to_reg   (o_mem_to_reg),
    .o_mem_read     (o_mem_read),
    .o_mem_write    (o_mem_write),
    .o_imm_flag     (o_imm_flag),
    .o_sign_flag    (o_sign_flag),
    .o_reg_write    (o_reg_write)
);

`default_nettype wire

/* tb_mips_decode.sv */
`default_nettype none
`include "mips_params.svh"

module tb_mips_decode
    import mips_isa_pkg::*;
    import mips_ctrl_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          NUM_INSTR    = 400;
    localparam int          MAX_CYCLES   = 2000;
    localparam int          RESET_CYCLES = 10;
    localparam int          PROG_WORDS   = 512;
    localparam logic [31:0] SEED         = 32'h708e7f72;

    // jump, branch, reg_dst, mem_to_reg, mem_read, mem_write, imm, sign, reg_write
    typedef struct packed {
        logic [8:0] bits;
        alu_src_e   alu_src;
        alu_op_e    alu_op;
        mem_width_e width;
    } ctrl_t;

    logic                clk;
    logic                i_rst_n;
    logic [`NB_DATA-1:0] i_instr;
    logic                i_stall;
    logic                i_wb_we;
    reg_addr_t           i_wb_addr;
    logic [`NB_DATA-1:0] i_wb_data;
    logic [`NB_DATA-1:0] o_pc;
    logic                o_hazard_stall;
    reg_addr_t           o_rs;
    reg_addr_t           o_rt;
    reg_addr_t           o_rd;
    logic [`NB_DATA-1:0] o_reg_da;
    logic [`NB_DATA-1:0] o_reg_db;
    logic [`NB_DATA-1:0] o_immediate;
    opcode_e             o_opcode;
    shamt_t              o_shamt;
    funct_e              o_func;
    logic [25:0]         o_addr;
    logic [`NB_DATA-1:0] o_pc4;
    logic                o_jump;
    logic                o_branch;
    logic                o_reg_dst;
    logic                o_mem_to_reg;
    logic                o_mem_read;
    logic                o_mem_write;
    logic                o_imm_flag;
    logic                o_sign_flag;
    logic                o_reg_write;
    alu_src_e            o_alu_src;
    alu_op_e             o_alu_op;
    mem_width_e          o_width;

    logic [31:0]   prog [PROG_WORDS];
    logic [31:0]   mregs [`REG_COUNT];
    logic [31:0]   m_pc;
    ctrl_t         m_ctrl;
    logic [31:0]   m_word;        // raw word held in ID/EX
    logic [31:0]   m_da;
    logic [31:0]   m_db;
    logic [31:0]   m_imm;
    logic [31:0]   m_pc4;
    logic          m_valid;       // payload loaded at least once
    logic          m_hz;
    hazard_state_e m_state;
    int            n_issued;
    int            n_hazard;
    int            n_ext_stall;

    mips_decode_top DUT (.*);

    // instruction memory, same-cycle answer
    assign i_instr = prog[o_pc[10:2]];

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "stopping at first failure");
    endtask

    task automatic word_cmp(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic bit_cmp(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic field_cmp(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic opcode_cmp(input string name, input opcode_e got, input opcode_e exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic funct_cmp(input string name, input funct_e got, input funct_e exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic aluop_cmp(input string name, input alu_op_e got, input alu_op_e exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic src_cmp(input string name, input alu_src_e got, input alu_src_e exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic width_cmp(input string name, input mem_width_e got, input mem_width_e exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    function automatic ctrl_t ctrl_row(input logic [8:0] bits, input alu_src_e src,
                                       input alu_op_e aop, input mem_width_e w);
        ctrl_t c;
        c.bits    = bits;
        c.alu_src = src;
        c.alu_op  = aop;
        c.width   = w;
        return c;
    endfunction

    // decode table, one row per instruction class
    function automatic ctrl_t expected_ctrl(input logic [31:0] w);
        funct_e fn;
        fn = funct_e'(w[5:0]);
        case (w[31:26])
            OP_RTYPE: begin
                if (fn inside {F_ADD, F_SUB, F_AND, F_OR, F_SLT, F_SLL}) begin
                    return ctrl_row(9'b001_000_001, (fn == F_SLL) ? SRC_SHAMT : SRC_REG,
                                    ALUOP_FUNCT, W_WORD);
                end
                return '0;  // unlisted funct
            end
            OP_ADDI: return ctrl_row(9'b000_000_111, SRC_IMM, ALUOP_ADD, W_WORD);
            OP_ANDI: return ctrl_row(9'b000_000_101, SRC_IMM, ALUOP_LOGIC, W_WORD);
            OP_ORI:  return ctrl_row(9'b000_000_101, SRC_IMM, ALUOP_LOGIC, W_WORD);
            OP_LW:   return ctrl_row(9'b000_110_111, SRC_IMM, ALUOP_ADD, W_WORD);
            OP_LH:   return ctrl_row(9'b000_110_111, SRC_IMM, ALUOP_ADD, W_HALF);
            OP_LB:   return ctrl_row(9'b000_110_111, SRC_IMM, ALUOP_ADD, W_BYTE);
            OP_SW:   return ctrl_row(9'b000_001_110, SRC_IMM, ALUOP_ADD, W_WORD);
            OP_BEQ:  return ctrl_row(9'b010_000_010, SRC_REG, ALUOP_SUB, W_WORD);
            OP_J:    return ctrl_row(9'b100_000_000, SRC_REG, ALUOP_ADD, W_WORD);
            default: return '0;
        endcase
    endfunction

    function automatic logic [31:0] random_instr();
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
        int          kind;
        rs   = 5'($urandom_range(0, 3));  // small pool, frequent load-use
        rt   = 5'($urandom_range(0, 3));
        imm  = 16'($urandom);
        kind = $urandom_range(0, 16);
        op   = OP_RTYPE;
        fn   = F_ADD;
        case (kind)
            0: fn = F_ADD;
            1: fn = F_SUB;
            2: fn = F_AND;
            3: fn = F_OR;
            4: fn = F_SLT;
            5: fn = F_SLL;
            6: op = OP_ADDI;
            7: op = OP_ANDI;
            8: op = OP_ORI;
            9: op = OP_LW;
            10: op = OP_LH;
            11: op = OP_LB;
            12: op = OP_SW;
            13: op = OP_BEQ;
            14: op = OP_J;
            15: op = 6'h30 + 6'($urandom_range(0, 7));  // illegal opcode
            default: fn = 6'h3f;                        // unlisted funct
        endcase
        if (op == OP_RTYPE) begin
            return {op, rs, rt, imm[15:6], fn};
        end
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] model_read(input reg_addr_t a);
        if (a == '0) begin
            return '0;
        end
        if (i_wb_we && (a == i_wb_addr)) begin
            return i_wb_data;  // writeback in the same cycle
        end
        return mregs[a];
    endfunction

    function automatic logic predict_hazard();
        logic [31:0] w;
        reg_addr_t   ex_rt;
        w     = prog[m_pc[10:2]];
        ex_rt = m_word[20:16];
        return (m_state == HZ_RUN) && m_ctrl.bits[4] && (ex_rt != '0) &&
               ((ex_rt == w[25:21]) || (ex_rt == w[20:16])) && !i_stall;
    endfunction

    task automatic compare_outputs();
        m_hz = predict_hazard();
        word_cmp("o_pc", o_pc, m_pc);
        bit_cmp("o_hazard_stall", o_hazard_stall, m_hz);
        bit_cmp("o_jump", o_jump, m_ctrl.bits[8]);
        bit_cmp("o_branch", o_branch, m_ctrl.bits[7]);
        bit_cmp("o_reg_dst", o_reg_dst, m_ctrl.bits[6]);
        bit_cmp("o_mem_to_reg", o_mem_to_reg, m_ctrl.bits[5]);
        bit_cmp("o_mem_read", o_mem_read, m_ctrl.bits[4]);
        bit_cmp("o_mem_write", o_mem_write, m_ctrl.bits[3]);
        bit_cmp("o_imm_flag", o_imm_flag, m_ctrl.bits[2]);
        bit_cmp("o_sign_flag", o_sign_flag, m_ctrl.bits[1]);
        bit_cmp("o_reg_write", o_reg_write, m_ctrl.bits[0]);
        src_cmp("o_alu_src", o_alu_src, m_ctrl.alu_src);
        aluop_cmp("o_alu_op", o_alu_op, m_ctrl.alu_op);
        width_cmp("o_width", o_width, m_ctrl.width);
        if (m_valid) begin
            field_cmp("o_rs", o_rs, m_word[25:21]);
            field_cmp("o_rt", o_rt, m_word[20:16]);
            field_cmp("o_rd", o_rd, m_word[15:11]);
            field_cmp("o_shamt", o_shamt, m_word[10:6]);
            opcode_cmp("o_opcode", o_opcode, opcode_e'(m_word[31:26]));
            funct_cmp("o_func", o_func, funct_e'(m_word[5:0]));
            word_cmp("o_addr", {6'b0, o_addr}, {6'b0, m_word[25:0]});
            word_cmp("o_reg_da", o_reg_da, m_da);
            word_cmp("o_reg_db", o_reg_db, m_db);
            word_cmp("o_immediate", o_immediate, m_imm);
            word_cmp("o_pc4", o_pc4, m_pc4);
        end
    endtask

    // bubble is an all-zero word with no controls
    task automatic load_idex(input ctrl_t c, input logic [31:0] w, input logic [31:0] da,
                             input logic [31:0] db, input logic [31:0] pc4);
        m_ctrl  = c;
        m_word  = w;
        m_da    = da;
        m_db    = db;
        m_pc4   = pc4;
        m_imm   = c.bits[1] ? {{16{w[15]}}, w[15:0]} : {16'h0000, w[15:0]};
        m_valid = 1'b1;
    endtask

    task automatic advance_model();
        logic [31:0] w;
        w = prog[m_pc[10:2]];
        if (i_stall) begin
            n_ext_stall++;
        end else if (m_hz) begin
            load_idex('0, 32'h0, 32'h0, 32'h0, 32'h0);
            m_state = HZ_BUBBLE;
            n_hazard++;
        end else begin
            load_idex(expected_ctrl(w), w, model_read(w[25:21]), model_read(w[20:16]),
                      m_pc + 32'd4);
            m_state = HZ_RUN;
            m_pc    = m_pc + 32'd4;
            n_issued++;
        end
        if (i_wb_we && (i_wb_addr != '0)) begin
            mregs[i_wb_addr] = i_wb_data;
        end
    endtask

    task automatic drive_inputs();
        i_stall   <= ($urandom_range(0, 99) < 10);
        i_wb_we   <= ($urandom_range(0, 99) < 30);
        i_wb_addr <= reg_addr_t'($urandom_range(0, 7));
        i_wb_data <= $urandom;
    endtask

    initial begin
        int cycles;
        void'($urandom(SEED));
        i_rst_n   = 1'b0;
        i_stall   = 1'b0;
        i_wb_we   = 1'b0;
        i_wb_addr = '0;
        i_wb_data = '0;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = random_instr();
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            mregs[i] = '0;
        end
        m_pc        = `PC_RESET;
        m_ctrl      = '0;
        m_word      = '0;
        m_valid     = 1'b0;  // payload has no reset
        m_state     = HZ_RUN;
        n_issued    = 0;
        n_hazard    = 0;
        n_ext_stall = 0;

        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
        end
        i_rst_n <= 1'b1;

        cycles = 0;
        while (n_issued < NUM_INSTR) begin
            if (cycles >= MAX_CYCLES) begin
                $display("timeout: only %0d instructions decoded in %0d cycles",
                         n_issued, cycles);
                abort_run();
            end
            @(negedge clk);
            compare_outputs();
            @(posedge clk);
            advance_model();
            drive_inputs();
            cycles++;
        end
        @(negedge clk);
        compare_outputs();

        if ((n_hazard > 0) && (n_ext_stall > 0)) begin
            $display("No errors");
            $finish;
        end else begin
            $display("random program hit no load-use stall or no external stall");
            $display("Errors found");
            $fatal(1, "stall behaviour was not exercised");
        end
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
mips_isa_pkg.sv
mips_ctrl_pkg.sv
ctrl_if.sv
pc_counter.sv
hazard_fsm.sv
register_file.sv
control_unit.sv
instruction_decode.sv
mips_decode_top.sv
mips_decode_properties.sv
tb_mips_decode.sv

/* Makefile */
# Verilator build of the decode slice testbench

VERILATOR ?= verilator
TOP       ?= tb_mips_decode
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := mips_params.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
